// File: include/vec_regmap.svh
`ifndef VEC_REGMAP_SVH
`define VEC_REGMAP_SVH

// Control and status registers
`define REG_CMD    32'h0000_0000
`define REG_VL     32'h0000_0004
`define REG_STATUS 32'h0000_0008

// One word per element of every vector register
`define ELEM_BASE  32'h0000_0100
`define ELEM_END   32'h0000_0300
`define ELEM_ADDR(vreg, idx) (`ELEM_BASE + (((vreg) * 16 + (idx)) * 4))

// Command word fields
`define CMD_OP_MSB  3
`define CMD_OP_LSB  0
`define CMD_VD_MSB  6
`define CMD_VD_LSB  4
`define CMD_VS1_MSB 10
`define CMD_VS1_LSB 8
`define CMD_VS2_MSB 14
`define CMD_VS2_LSB 12

// Status word fields
`define STATUS_BUSY_BIT 0
`define STATUS_DONE_LSB 8
`define STATUS_DONE_MSB 15

`endif

// File: verilog/vec_pkg.sv
package vec_pkg;

  // Machine geometry
  localparam int unsigned NrLanes      = 4;
  localparam int unsigned ElemWidth    = 32;
  localparam int unsigned NrVRegs      = 8;
  localparam int unsigned ElemsPerLane = 4;
  localparam int unsigned VLMax        = NrLanes * ElemsPerLane;

  // Index widths derived from the geometry
  localparam int unsigned VRegIdxW = $clog2(NrVRegs);
  localparam int unsigned SlotIdxW = $clog2(ElemsPerLane);
  localparam int unsigned LaneIdxW = $clog2(NrLanes);
  localparam int unsigned ElemIdxW = $clog2(VLMax);
  localparam int unsigned VlWidth  = $clog2(VLMax + 1);

  // Host bus
  localparam int unsigned AxiAddrWidth = 32;
  localparam int unsigned AxiDataWidth = 32;
  localparam logic [1:0]  RespOkay     = 2'b00;
  localparam logic [1:0]  RespSlvErr   = 2'b10;

  typedef logic [ElemWidth-1:0] elem_t;
  typedef logic [VRegIdxW-1:0]  vreg_t;
  typedef logic [SlotIdxW-1:0]  slot_t;
  typedef logic [LaneIdxW-1:0]  lane_t;
  typedef logic [VlWidth-1:0]   vl_t;

  typedef enum logic [3:0] {
    OP_VADD  = 4'd0,
    OP_VSUB  = 4'd1,
    OP_VAND  = 4'd2,
    OP_VOR   = 4'd3,
    OP_VXOR  = 4'd4,
    OP_VMUL  = 4'd5,
    OP_VMACC = 4'd6
  } vfu_op_e;

  // Instruction as broadcast to every lane
  typedef struct packed {
    vfu_op_e op;
    vreg_t   vd;
    vreg_t   vs1;
    vreg_t   vs2;
    vl_t     vl;
  } vfu_operation_t;

  // Operand a is read from vs2 and b from vs1
  // c carries the old vd value for accumulate
  typedef struct packed {
    vfu_op_e op;
    elem_t   a;
    elem_t   b;
    elem_t   c;
    vreg_t   vd;
    slot_t   slot;
  } elem_op_t;

  typedef struct packed {
    vreg_t vreg;
    slot_t slot;
    elem_t data;
  } wb_req_t;

endpackage

// File: verilog/vec_alu.sv
module vec_alu import vec_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  elem_op_t op_i,
  input  logic     valid_i,
  output logic     ready_o,
  output wb_req_t  result_o,
  output logic     valid_o,
  input  logic     ready_i
);

  elem_t   res;
  wb_req_t result_q;
  logic    valid_q;

  always_comb begin
    case (op_i.op)
      OP_VADD: res = op_i.a + op_i.b;
      OP_VSUB: res = op_i.a - op_i.b;
      OP_VAND: res = op_i.a & op_i.b;
      OP_VOR:  res = op_i.a | op_i.b;
      OP_VXOR: res = op_i.a ^ op_i.b;
      default: res = '0;
    endcase
  end

  // Output register accepts when empty or draining
  assign ready_o = !valid_q || ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      result_q.vreg <= op_i.vd;
      result_q.slot <= op_i.slot;
      result_q.data <= res;
    end
  end

  assign result_o = result_q;
  assign valid_o  = valid_q;

endmodule

// File: verilog/vec_mul.sv
module vec_mul import vec_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  elem_op_t op_i,
  input  logic     valid_i,
  output logic     ready_o,
  output wb_req_t  result_o,
  output logic     valid_o,
  input  logic     ready_i
);

  // Contents of the multiply stage
  typedef struct packed {
    logic  acc;
    elem_t prod;
    elem_t addend;
    vreg_t vreg;
    slot_t slot;
  } mul_stage_t;

  mul_stage_t s1_q;
  wb_req_t    s2_q;
  logic       s1_valid_q, s2_valid_q;
  logic       s1_ready, s2_ready;

  // Each stage moves when the one after it has room
  assign s2_ready = !s2_valid_q || ready_i;
  assign s1_ready = !s1_valid_q || s2_ready;
  assign ready_o  = s1_ready;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      if (s1_ready) s1_valid_q <= valid_i;
      if (s2_ready) s2_valid_q <= s1_valid_q;
    end
  end

  // Stage 1 keeps the low half of the product
  always_ff @(posedge clk_i) begin
    if (valid_i && s1_ready) begin
      s1_q.acc    <= op_i.op == OP_VMACC;
      s1_q.prod   <= elem_t'(op_i.a * op_i.b);
      s1_q.addend <= op_i.c;
      s1_q.vreg   <= op_i.vd;
      s1_q.slot   <= op_i.slot;
    end
  end

  // Stage 2 adds the old destination for accumulate
  always_ff @(posedge clk_i) begin
    if (s1_valid_q && s2_ready) begin
      s2_q.vreg <= s1_q.vreg;
      s2_q.slot <= s1_q.slot;
      s2_q.data <= s1_q.acc ? s1_q.prod + s1_q.addend : s1_q.prod;
    end
  end

  assign result_o = s2_q;
  assign valid_o  = s2_valid_q;

  a_hold_on_stall: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_o && !ready_i |=> valid_o && $stable(result_o));

endmodule

// File: verilog/vec_fus_stage.sv
module vec_fus_stage import vec_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  // Sequencer side
  input  elem_op_t elem_op_i,
  input  logic     elem_valid_i,
  output logic     elem_ready_o,
  // Register file side
  output wb_req_t  wb_o,
  output logic     wb_valid_o,
  input  logic     wb_ready_i
);

  logic    is_mul;
  logic    alu_ready, mul_ready;
  logic    alu_valid, mul_valid, alu_out_ready;
  wb_req_t alu_res, mul_res;

  // Multiply class goes to the pipelined unit
  assign is_mul       = elem_op_i.op inside {OP_VMUL, OP_VMACC};
  assign elem_ready_o = is_mul ? mul_ready : alu_ready;

  ////////////////////////////////////////
  // Vector ALU
  ////////////////////////////////////////

  vec_alu i_valu (
    .clk_i   (clk_i                  ),
    .reset_i (reset_i                ),
    .op_i    (elem_op_i              ),
    .valid_i (elem_valid_i && !is_mul),
    .ready_o (alu_ready              ),
    .result_o(alu_res                ),
    .valid_o (alu_valid              ),
    .ready_i (alu_out_ready          )
  );

  ////////////////////////////////////////
  // Vector multiplier
  ////////////////////////////////////////

  vec_mul i_vmul (
    .clk_i   (clk_i                 ),
    .reset_i (reset_i               ),
    .op_i    (elem_op_i             ),
    .valid_i (elem_valid_i && is_mul),
    .ready_o (mul_ready             ),
    .result_o(mul_res               ),
    .valid_o (mul_valid             ),
    .ready_i (wb_ready_i            )
  );

  // Multiplier results take the write port first
  assign alu_out_ready = wb_ready_i && !mul_valid;
  assign wb_valid_o    = mul_valid || alu_valid;
  assign wb_o          = mul_valid ? mul_res : alu_res;

endmodule

// File: verilog/vec_lane.sv
module vec_lane import vec_pkg::*; #(
  parameter int unsigned LaneIdx = 0
) (
  input  logic           clk_i,
  input  logic           reset_i,
  input  vfu_operation_t op_i,
  input  logic           op_valid_i,
  input  logic           elem_we_i,
  input  wb_req_t        elem_wr_i,
  input  vreg_t          rd_reg_i,
  input  slot_t          rd_slot_i,
  output elem_t          rd_data_o,
  output logic           done_o
);

  typedef logic [SlotIdxW:0] cnt_t;

  elem_t          vrf_q [NrVRegs][ElemsPerLane];
  vfu_operation_t insn_q;
  cnt_t           lane_elems, n_q, issue_q, wb_cnt_q;
  logic           active_q, done_q;
  slot_t          issue_slot;
  elem_op_t       elem_op;
  logic           elem_valid, elem_ready;
  wb_req_t        wb;
  logic           wb_valid;

  ////////////////////////////////////////
  // Register file slice
  ////////////////////////////////////////

  // Write-back wins, host writes only arrive while idle
  always_ff @(posedge clk_i) begin
    if (wb_valid) begin
      vrf_q[wb.vreg][wb.slot] <= wb.data;
    end else if (elem_we_i) begin
      vrf_q[elem_wr_i.vreg][elem_wr_i.slot] <= elem_wr_i.data;
    end
  end

  assign rd_data_o = vrf_q[rd_reg_i][rd_slot_i];

  ////////////////////////////////////////
  // Element sequencer
  ////////////////////////////////////////

  // Slot s of this lane holds element s * NrLanes + LaneIdx
  always_comb begin
    lane_elems = '0;
    for (int unsigned s = 0; s < ElemsPerLane; s++) begin
      if (s * NrLanes + LaneIdx < op_i.vl) lane_elems = lane_elems + 1'b1;
    end
  end

  assign issue_slot   = issue_q[SlotIdxW-1:0];
  assign elem_valid   = active_q && (issue_q < n_q);
  assign elem_op.op   = insn_q.op;
  assign elem_op.a    = vrf_q[insn_q.vs2][issue_slot];
  assign elem_op.b    = vrf_q[insn_q.vs1][issue_slot];
  assign elem_op.c    = vrf_q[insn_q.vd][issue_slot];
  assign elem_op.vd   = insn_q.vd;
  assign elem_op.slot = issue_slot;

  always_ff @(posedge clk_i) begin
    if (op_valid_i) insn_q <= op_i;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_q <= 1'b0;
      done_q   <= 1'b0;
      n_q      <= '0;
      issue_q  <= '0;
      wb_cnt_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (op_valid_i) begin
        // an empty share finishes right away
        active_q <= lane_elems != '0;
        done_q   <= lane_elems == '0;
        n_q      <= lane_elems;
        issue_q  <= '0;
        wb_cnt_q <= '0;
      end else if (active_q) begin
        if (elem_valid && elem_ready) issue_q <= issue_q + 1'b1;
        if (wb_valid) begin
          wb_cnt_q <= wb_cnt_q + 1'b1;
          if (wb_cnt_q + 1'b1 == n_q) begin
            active_q <= 1'b0;
            done_q   <= 1'b1;
          end
        end
      end
    end
  end

  assign done_o = done_q;

  vec_fus_stage i_fus_stage (
    .clk_i       (clk_i     ),
    .reset_i     (reset_i   ),
    .elem_op_i   (elem_op   ),
    .elem_valid_i(elem_valid),
    .elem_ready_o(elem_ready),
    .wb_o        (wb        ),
    .wb_valid_o  (wb_valid  ),
    .wb_ready_i  (1'b1      )
  );

endmodule

// File: verilog/vec_completion.sv
module vec_completion import vec_pkg::*; (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic         [NrLanes-1:0] lane_done_i,
  input  elem_t        [NrLanes-1:0] lane_rd_data_i,
  input  lane_t                     rd_lane_i,
  output elem_t                     rd_data_o,
  output logic                      insn_done_o
);

  logic [NrLanes-1:0] seen_q;
  logic               all_done;

  // Lanes finish at different times
  assign all_done    = &seen_q;
  assign insn_done_o = all_done;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      seen_q <= '0;
    end else if (all_done) begin
      seen_q <= '0;
    end else begin
      seen_q <= seen_q | lane_done_i;
    end
  end

  assign rd_data_o = lane_rd_data_i[rd_lane_i];

endmodule

// File: verilog/vec_axil_dispatcher.sv
`include "vec_regmap.svh"

module vec_axil_dispatcher import vec_pkg::*; (
  input  logic                    clk_i,
  input  logic                    reset_i,
  // AXI4-Lite slave
  input  logic [AxiAddrWidth-1:0] s_awaddr_i,
  input  logic                    s_awvalid_i,
  output logic                    s_awready_o,
  input  logic [AxiDataWidth-1:0] s_wdata_i,
  input  logic                    s_wvalid_i,
  output logic                    s_wready_o,
  output logic [1:0]              s_bresp_o,
  output logic                    s_bvalid_o,
  input  logic                    s_bready_i,
  input  logic [AxiAddrWidth-1:0] s_araddr_i,
  input  logic                    s_arvalid_i,
  output logic                    s_arready_o,
  output logic [AxiDataWidth-1:0] s_rdata_o,
  output logic [1:0]              s_rresp_o,
  output logic                    s_rvalid_o,
  input  logic                    s_rready_i,
  // Lanes
  output vfu_operation_t          op_o,
  output logic                    op_valid_o,
  output logic [NrLanes-1:0]      elem_we_o,
  output wb_req_t                 elem_wr_o,
  output vreg_t                   rd_reg_o,
  output logic [ElemIdxW-1:0]     rd_elem_o,
  input  elem_t                   rd_data_i,
  input  logic                    insn_done_i
);

  logic                    aw_got_q, w_got_q, bvalid_q, rvalid_q;
  logic [AxiAddrWidth-1:0] awaddr_q, wr_addr, wr_off, rd_off;
  logic [AxiDataWidth-1:0] wdata_q, wr_data, rdata_q, rd_value;
  logic [1:0]              bresp_q, rresp_q;
  logic                    aw_hs, w_hs, ar_hs, wr_fire;
  logic                    cmd_go, vl_go, elem_go, wr_err, rd_err;
  logic [ElemIdxW-1:0]     wr_idx;
  vl_t                     vl_q;
  logic                    busy_q, op_valid_q;
  logic [7:0]              done_cnt_q;
  vfu_operation_t          op_q;

  function automatic logic in_elem_window(logic [AxiAddrWidth-1:0] addr);
    return addr >= `ELEM_BASE && addr < `ELEM_END && addr[1:0] == 2'b00;
  endfunction

  ////////////////////////////////////////
  // Write channels
  ////////////////////////////////////////

  assign s_awready_o = !bvalid_q && !aw_got_q;
  assign s_wready_o  = !bvalid_q && !w_got_q;
  assign aw_hs       = s_awvalid_i && s_awready_o;
  assign w_hs        = s_wvalid_i && s_wready_o;
  assign wr_addr     = aw_hs ? s_awaddr_i : awaddr_q;
  assign wr_data     = w_hs ? s_wdata_i : wdata_q;
  assign wr_fire     = (aw_hs || aw_got_q) && (w_hs || w_got_q);
  assign wr_off      = wr_addr - `ELEM_BASE;
  assign wr_idx      = wr_off[2 +: ElemIdxW];

  // Anything not matched below is rejected
  always_comb begin
    cmd_go  = 1'b0;
    vl_go   = 1'b0;
    elem_go = 1'b0;
    wr_err  = 1'b1;
    if (wr_addr == `REG_CMD) begin
      cmd_go = !busy_q;
      wr_err = busy_q;
    end else if (wr_addr == `REG_VL) begin
      vl_go  = !busy_q && wr_data <= VLMax;
      wr_err = !vl_go;
    end else if (in_elem_window(wr_addr)) begin
      elem_go = !busy_q;
      wr_err  = busy_q;
    end
  end

  // Element index splits into lane (low bits) and slot
  always_comb begin
    elem_we_o = '0;
    elem_we_o[wr_idx[LaneIdxW-1:0]] = wr_fire && elem_go;
  end

  assign elem_wr_o.vreg = wr_off[2 + ElemIdxW +: VRegIdxW];
  assign elem_wr_o.slot = wr_idx[LaneIdxW +: SlotIdxW];
  assign elem_wr_o.data = wr_data;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      aw_got_q <= 1'b0;
      w_got_q  <= 1'b0;
      bvalid_q <= 1'b0;
    end else if (wr_fire) begin
      aw_got_q <= 1'b0;
      w_got_q  <= 1'b0;
      bvalid_q <= 1'b1;
    end else begin
      if (aw_hs) aw_got_q <= 1'b1;
      if (w_hs) w_got_q <= 1'b1;
      if (s_bready_i) bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) awaddr_q <= s_awaddr_i;
    if (w_hs) wdata_q <= s_wdata_i;
    if (wr_fire) bresp_q <= wr_err ? RespSlvErr : RespOkay;
  end

  assign s_bvalid_o = bvalid_q;
  assign s_bresp_o  = bresp_q;

  ////////////////////////////////////////
  // Control state
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      vl_q       <= '0;
      busy_q     <= 1'b0;
      op_valid_q <= 1'b0;
      done_cnt_q <= '0;
    end else begin
      op_valid_q <= wr_fire && cmd_go;
      if (wr_fire && vl_go) vl_q <= vl_t'(wr_data);
      if (wr_fire && cmd_go) begin
        busy_q <= 1'b1;
      end else if (insn_done_i) begin
        busy_q     <= 1'b0;
        done_cnt_q <= done_cnt_q + 8'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire && cmd_go) begin
      op_q.op  <= vfu_op_e'(wr_data[`CMD_OP_MSB:`CMD_OP_LSB]);
      op_q.vd  <= wr_data[`CMD_VD_MSB:`CMD_VD_LSB];
      op_q.vs1 <= wr_data[`CMD_VS1_MSB:`CMD_VS1_LSB];
      op_q.vs2 <= wr_data[`CMD_VS2_MSB:`CMD_VS2_LSB];
      op_q.vl  <= vl_q;
    end
  end

  assign op_o       = op_q;
  assign op_valid_o = op_valid_q;

  ////////////////////////////////////////
  // Read channels
  ////////////////////////////////////////

  assign s_arready_o = !rvalid_q;
  assign ar_hs       = s_arvalid_i && s_arready_o;
  assign rd_off      = s_araddr_i - `ELEM_BASE;
  assign rd_reg_o    = rd_off[2 + ElemIdxW +: VRegIdxW];
  assign rd_elem_o   = rd_off[2 +: ElemIdxW];

  // Command register is write-only and reads as zero
  always_comb begin
    rd_value = '0;
    rd_err   = 1'b0;
    if (s_araddr_i == `REG_VL) begin
      rd_value = AxiDataWidth'(vl_q);
    end else if (s_araddr_i == `REG_STATUS) begin
      rd_value[`STATUS_BUSY_BIT] = busy_q;
      rd_value[`STATUS_DONE_MSB:`STATUS_DONE_LSB] = done_cnt_q;
    end else if (in_elem_window(s_araddr_i)) begin
      rd_value = rd_data_i;
    end else if (s_araddr_i != `REG_CMD) begin
      rd_err = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else if (ar_hs) begin
      rvalid_q <= 1'b1;
    end else if (s_rready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      rdata_q <= rd_value;
      rresp_q <= rd_err ? RespSlvErr : RespOkay;
    end
  end

  assign s_rvalid_o = rvalid_q;
  assign s_rdata_o  = rdata_q;
  assign s_rresp_o  = rresp_q;

  // Completion only ends an instruction that was broadcast
  a_done_while_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    insn_done_i |-> busy_q);

endmodule

// File: verilog/vec_top.sv
module vec_top import vec_pkg::*; (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic [AxiAddrWidth-1:0] s_awaddr_i,
  input  logic                    s_awvalid_i,
  output logic                    s_awready_o,
  input  logic [AxiDataWidth-1:0] s_wdata_i,
  input  logic                    s_wvalid_i,
  output logic                    s_wready_o,
  output logic [1:0]              s_bresp_o,
  output logic                    s_bvalid_o,
  input  logic                    s_bready_i,
  input  logic [AxiAddrWidth-1:0] s_araddr_i,
  input  logic                    s_arvalid_i,
  output logic                    s_arready_o,
  output logic [AxiDataWidth-1:0] s_rdata_o,
  output logic [1:0]              s_rresp_o,
  output logic                    s_rvalid_o,
  input  logic                    s_rready_i
);

  vfu_operation_t      op;
  logic                op_valid, insn_done;
  logic [NrLanes-1:0]  elem_we, lane_done;
  wb_req_t             elem_wr;
  vreg_t               rd_reg;
  logic [ElemIdxW-1:0] rd_elem;
  elem_t [NrLanes-1:0] lane_rd_data;
  elem_t               rd_data;

  vec_axil_dispatcher i_dispatcher (
    .clk_i      (clk_i      ),
    .reset_i    (reset_i    ),
    .s_awaddr_i (s_awaddr_i ),
    .s_awvalid_i(s_awvalid_i),
    .s_awready_o(s_awready_o),
    .s_wdata_i  (s_wdata_i  ),
    .s_wvalid_i (s_wvalid_i ),
    .s_wready_o (s_wready_o ),
    .s_bresp_o  (s_bresp_o  ),
    .s_bvalid_o (s_bvalid_o ),
    .s_bready_i (s_bready_i ),
    .s_araddr_i (s_araddr_i ),
    .s_arvalid_i(s_arvalid_i),
    .s_arready_o(s_arready_o),
    .s_rdata_o  (s_rdata_o  ),
    .s_rresp_o  (s_rresp_o  ),
    .s_rvalid_o (s_rvalid_o ),
    .s_rready_i (s_rready_i ),
    .op_o       (op         ),
    .op_valid_o (op_valid   ),
    .elem_we_o  (elem_we    ),
    .elem_wr_o  (elem_wr    ),
    .rd_reg_o   (rd_reg     ),
    .rd_elem_o  (rd_elem    ),
    .rd_data_i  (rd_data    ),
    .insn_done_i(insn_done  )
  );

  // Element i lives in lane i mod NrLanes
  for (genvar i = 0; i < NrLanes; i++) begin : gen_lanes
    vec_lane #(
      .LaneIdx(i)
    ) i_lane (
      .clk_i     (clk_i                          ),
      .reset_i   (reset_i                        ),
      .op_i      (op                             ),
      .op_valid_i(op_valid                       ),
      .elem_we_i (elem_we[i]                     ),
      .elem_wr_i (elem_wr                        ),
      .rd_reg_i  (rd_reg                         ),
      .rd_slot_i (rd_elem[LaneIdxW +: SlotIdxW]  ),
      .rd_data_o (lane_rd_data[i]                ),
      .done_o    (lane_done[i]                   )
    );
  end

  vec_completion i_completion (
    .clk_i         (clk_i                   ),
    .reset_i       (reset_i                 ),
    .lane_done_i   (lane_done               ),
    .lane_rd_data_i(lane_rd_data            ),
    .rd_lane_i     (rd_elem[LaneIdxW-1:0]   ),
    .rd_data_o     (rd_data                 ),
    .insn_done_o   (insn_done               )
  );

endmodule

// File: testbench/tb_vec_top.sv
`include "vec_regmap.svh"

module tb_vec_top import vec_pkg::*; ();

  localparam int unsigned ClkPeriod   = 100;
  localparam int unsigned ResetCycles = 16;
  localparam int unsigned NumTests    = 6;
  // Cycles allowed per test
  localparam int unsigned TestBudget  = 4000;
  localparam int unsigned PollLimit   = 200;

  logic        clk;
  logic        reset;
  logic [31:0] awaddr, wdata, araddr, rdata;
  logic        awvalid, wvalid, bready, arvalid, rready;
  logic        awready, wready, bvalid, arready, rvalid;
  logic [1:0]  bresp, rresp;

  // Reference register file, indexed by register and element
  elem_t       model_q [NrVRegs][VLMax];
  logic [31:0] lcg_state;
  int unsigned cur_vl;
  logic [7:0]  exp_done;
  int unsigned err_cnt, tests_run, tests_failed;

  initial clk = 1'b0;
  always #(ClkPeriod / 2) clk = ~clk;

  vec_top i_dut (
    .clk_i      (clk    ),
    .reset_i    (reset  ),
    .s_awaddr_i (awaddr ),
    .s_awvalid_i(awvalid),
    .s_awready_o(awready),
    .s_wdata_i  (wdata  ),
    .s_wvalid_i (wvalid ),
    .s_wready_o (wready ),
    .s_bresp_o  (bresp  ),
    .s_bvalid_o (bvalid ),
    .s_bready_i (bready ),
    .s_araddr_i (araddr ),
    .s_arvalid_i(arvalid),
    .s_arready_o(arready),
    .s_rdata_o  (rdata  ),
    .s_rresp_o  (rresp  ),
    .s_rvalid_o (rvalid ),
    .s_rready_i (rready )
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] cmd_word(vfu_op_e op, int unsigned vd, int unsigned vs1,
                                           int unsigned vs2);
    logic [31:0] w;
    w = '0;
    w[`CMD_OP_MSB:`CMD_OP_LSB]   = op;
    w[`CMD_VD_MSB:`CMD_VD_LSB]   = 3'(vd);
    w[`CMD_VS1_MSB:`CMD_VS1_LSB] = 3'(vs1);
    w[`CMD_VS2_MSB:`CMD_VS2_LSB] = 3'(vs2);
    return w;
  endfunction

  // Element result, a from vs2, b from vs1, c is the old vd
  function automatic elem_t model_result(vfu_op_e op, elem_t a, elem_t b, elem_t c);
    elem_t r;
    case (op)
      OP_VADD:  r = a + b;
      OP_VSUB:  r = a - b;
      OP_VAND:  r = a & b;
      OP_VOR:   r = a | b;
      OP_VXOR:  r = a ^ b;
      OP_VMUL:  r = a * b;
      OP_VMACC: r = a * b + c;
      default:  r = '0;
    endcase
    return r;
  endfunction

  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [1:0] exp_resp);
    @(negedge clk);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wvalid  = 1'b1;
    bready  = 1'b1;
    while (!(awready && wready)) @(negedge clk);
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) @(negedge clk);
    // No new write is taken while the response waits
    if ({awready, wready} !== 2'b00) begin
      $display("Fail s_awready_o,s_wready_o with B pending: got 0x%h, expected 0x%h",
               {awready, wready}, 2'b00);
      err_cnt++;
    end
    if (bresp !== exp_resp) begin
      $display("Fail s_bresp_o at 0x%h: got 0x%h, expected 0x%h", addr, bresp, exp_resp);
      err_cnt++;
    end
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                           input logic [1:0] exp_resp);
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    while (!arready) @(negedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    while (!rvalid) @(negedge clk);
    if (arready !== 1'b0) begin
      $display("Fail s_arready_o with R pending: got 0x%h, expected 0x%h", arready, 1'b0);
      err_cnt++;
    end
    data = rdata;
    if (rresp !== exp_resp) begin
      $display("Fail s_rresp_o at 0x%h: got 0x%h, expected 0x%h", addr, rresp, exp_resp);
      err_cnt++;
    end
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic write_elem(input int unsigned r, input int unsigned i, input elem_t d);
    model_q[r][i] = d;
    axil_write(`ELEM_ADDR(r, i), d, RespOkay);
  endtask

  task automatic set_vl(input int unsigned vl);
    axil_write(`REG_VL, 32'(vl), RespOkay);
    cur_vl = vl;
  endtask

  task automatic launch_insn(input vfu_op_e op, input int unsigned vd, input int unsigned vs1,
                             input int unsigned vs2);
    axil_write(`REG_CMD, cmd_word(op, vd, vs1, vs2), RespOkay);
    for (int unsigned i = 0; i < cur_vl; i++) begin
      model_q[vd][i] = model_result(op, model_q[vs2][i], model_q[vs1][i], model_q[vd][i]);
    end
    exp_done = exp_done + 8'd1;
  endtask

  // Poll STATUS until busy drops, then check the done count
  task automatic wait_idle();
    logic [31:0] status;
    int unsigned polls;
    polls = 0;
    axil_read(`REG_STATUS, status, RespOkay);
    while (status[`STATUS_BUSY_BIT] && polls < PollLimit) begin
      axil_read(`REG_STATUS, status, RespOkay);
      polls++;
    end
    if (status[`STATUS_BUSY_BIT]) begin
      $display("Busy did not clear after %0d status polls", PollLimit);
      err_cnt++;
    end else if (status !== {16'h0, exp_done, 8'h00}) begin
      $display("Fail s_rdata_o STATUS: got 0x%h, expected 0x%h", status,
               {16'h0, exp_done, 8'h00});
      err_cnt++;
    end
  endtask

  task automatic run_insn(input vfu_op_e op, input int unsigned vd, input int unsigned vs1,
                          input int unsigned vs2);
    launch_insn(op, vd, vs1, vs2);
    wait_idle();
  endtask

  task automatic check_regs();
    logic [31:0] d;
    for (int unsigned r = 0; r < NrVRegs; r++) begin
      for (int unsigned i = 0; i < VLMax; i++) begin
        axil_read(`ELEM_ADDR(r, i), d, RespOkay);
        if (d !== model_q[r][i]) begin
          $display("Fail s_rdata_o v%0d[%0d]: got 0x%h, expected 0x%h", r, i, d,
                   model_q[r][i]);
          err_cnt++;
        end
      end
    end
  endtask

  task automatic finish_test(input string name, input int unsigned start_errs);
    tests_run++;
    if (err_cnt == start_errs) begin
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", name, err_cnt - start_errs);
    end
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic reset_and_elements();
    int unsigned start;
    logic [31:0] d;
    start = err_cnt;
    axil_read(`REG_STATUS, d, RespOkay);
    if (d !== 32'h0) begin
      $display("Fail s_rdata_o STATUS after reset: got 0x%h, expected 0x%h", d, 32'h0);
      err_cnt++;
    end
    for (int unsigned r = 0; r < NrVRegs; r++) begin
      for (int unsigned i = 0; i < VLMax; i++) begin
        write_elem(r, i, next_rand());
      end
    end
    check_regs();
    finish_test("reset_and_elements", start);
  endtask

  task automatic alu_ops();
    int unsigned start;
    start = err_cnt;
    set_vl(16);
    // Sum that wraps past 2^32
    write_elem(1, 0, 32'hffff_fff0);
    write_elem(2, 0, 32'h0000_0020);
    run_insn(OP_VADD, 3, 1, 2);
    check_regs();
    run_insn(OP_VSUB, 4, 3, 0);
    check_regs();
    run_insn(OP_VAND, 5, 6, 7);
    check_regs();
    run_insn(OP_VOR, 6, 2, 4);
    check_regs();
    // Destination doubles as a source
    run_insn(OP_VXOR, 1, 1, 5);
    check_regs();
    finish_test("alu_ops", start);
  endtask

  task automatic mul_ops();
    int unsigned start;
    start = err_cnt;
    set_vl(7);
    write_elem(1, 3, 32'h8000_0001);
    write_elem(2, 3, 32'h0001_0003);
    run_insn(OP_VMUL, 7, 1, 2);
    check_regs();
    run_insn(OP_VMACC, 7, 3, 4);
    check_regs();
    finish_test("mul_ops", start);
  endtask

  task automatic rejected_writes();
    int unsigned start;
    logic [31:0] d;
    start = err_cnt;
    set_vl(16);
    launch_insn(OP_VMUL, 2, 3, 4);
    axil_write(`REG_CMD, cmd_word(OP_VADD, 0, 1, 2), RespSlvErr);
    wait_idle();
    launch_insn(OP_VMACC, 3, 5, 6);
    axil_write(`REG_VL, 32'd5, RespSlvErr);
    wait_idle();
    axil_read(`REG_VL, d, RespOkay);
    if (d !== 32'd16) begin
      $display("Fail s_rdata_o VL: got 0x%h, expected 0x%h", d, 32'd16);
      err_cnt++;
    end
    launch_insn(OP_VMUL, 4, 1, 7);
    axil_write(`ELEM_ADDR(0, 9), 32'hdead_beef, RespSlvErr);
    wait_idle();
    // Errors while idle
    axil_write(`REG_VL, 32'd17, RespSlvErr);
    axil_read(`REG_VL, d, RespOkay);
    if (d !== 32'd16) begin
      $display("Fail s_rdata_o VL: got 0x%h, expected 0x%h", d, 32'd16);
      err_cnt++;
    end
    axil_write(`REG_STATUS, 32'hffff_ffff, RespSlvErr);
    axil_write(`ELEM_END, 32'h1, RespSlvErr);
    axil_read(32'h0000_0040, d, RespSlvErr);
    if (d !== 32'h0) begin
      $display("Fail s_rdata_o unmapped: got 0x%h, expected 0x%h", d, 32'h0);
      err_cnt++;
    end
    wait_idle();
    check_regs();
    finish_test("rejected_writes", start);
  endtask

  task automatic done_count();
    int unsigned start;
    logic [31:0] after;
    start = err_cnt;
    set_vl(9);
    run_insn(OP_VOR, 0, 5, 6);
    run_insn(OP_VADD, 5, 0, 0);
    run_insn(OP_VMUL, 6, 5, 2);
    axil_read(`REG_STATUS, after, RespOkay);
    if (after !== {16'h0, exp_done, 8'h00}) begin
      $display("Fail s_rdata_o STATUS after three instructions: got 0x%h, expected 0x%h",
               after, {16'h0, exp_done, 8'h00});
      err_cnt++;
    end
    check_regs();
    finish_test("done_count", start);
  endtask

  task automatic vl_zero();
    int unsigned start;
    start = err_cnt;
    set_vl(0);
    run_insn(OP_VXOR, 2, 0, 1);
    run_insn(OP_VMACC, 3, 4, 5);
    check_regs();
    finish_test("vl_zero", start);
  endtask

  ////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////

  initial begin
    reset        = 1'b1;
    awaddr       = '0;
    awvalid      = 1'b0;
    wdata        = '0;
    wvalid       = 1'b0;
    bready       = 1'b0;
    araddr       = '0;
    arvalid      = 1'b0;
    rready       = 1'b0;
    lcg_state    = 32'h61d46fb0;
    cur_vl       = 0;
    exp_done     = '0;
    err_cnt      = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (ResetCycles) @(negedge clk);
    reset = 1'b0;

    reset_and_elements();
    alu_ops();
    mul_ops();
    rejected_writes();
    done_count();
    vl_zero();

    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    #(NumTests * TestBudget * ClkPeriod);
    $display("Watchdog expired, the tests did not finish within %0d cycles",
             NumTests * TestBudget);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+include
verilog/vec_pkg.sv
verilog/vec_alu.sv
verilog/vec_mul.sv
verilog/vec_fus_stage.sv
verilog/vec_lane.sv
verilog/vec_completion.sv
verilog/vec_axil_dispatcher.sv
verilog/vec_top.sv
testbench/tb_vec_top.sv

// File: Bender.yml
package:
  name: vec_unit

export_include_dirs:
  - include

sources:
  - files:
      - verilog/vec_pkg.sv
      - verilog/vec_alu.sv
      - verilog/vec_mul.sv
      - verilog/vec_fus_stage.sv
      - verilog/vec_lane.sv
      - verilog/vec_completion.sv
      - verilog/vec_axil_dispatcher.sv
      - verilog/vec_top.sv
  - target: test
    files:
      - testbench/tb_vec_top.sv
